// File: Makefile
# Verilator build and run for the VC allocator

VERILATOR ?= verilator
TOP       ?= tb_vc_alloc
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_vc_alloc.sv
// VC allocator testbench
`timescale 1ns/1ps
`default_nettype none

module tb_vc_alloc;

   localparam int clk_period        = 40;
   localparam int reset_cycles      = 3;
   localparam int single_cycles     = 40;
   localparam int contention_cycles = 200;
   localparam int inelig_cycles     = 60;
   localparam int last_class_cycles = 60;
   localparam int rr_cycles         = 5;
   localparam int blocked_port      = 2;
   // two resets plus the closing wait
   localparam int total_cycles = 2 * reset_cycles + single_cycles + contention_cycles
                                 + inelig_cycles + last_class_cycles + rr_cycles + 3;

   logic clk;
   logic rst_n;
   int   test_id;
   int   err_count;
   int   seed;

   vca_pkg::vc_req_t  req_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs];
   vca_pkg::vc_oh_u   elig_op_ovc [vca_pkg::num_ports];
   vca_pkg::ivc_gnt_t gnt_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs];
   vca_pkg::ovc_gnt_t gnt_op_ovc  [vca_pkg::num_ports][vca_pkg::num_vcs];

   vc_alloc_sep_if DUT
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_ip_ivc  (req_ip_ivc),
      .elig_op_ovc (elig_op_ovc),
      .gnt_ip_ivc  (gnt_ip_ivc),
      .gnt_op_ovc  (gnt_op_ovc)
   );

   vca_checker u_checker
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .test_id   (test_id),
      .err_count (err_count)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic clear_requests;
      for (int ip = 0; ip < vca_pkg::num_ports; ip++)
         for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
            req_ip_ivc[ip][ivc] <= '0;
   endtask

   // one-hot route_op and one-hot route_orc
   task automatic random_request(input int ip, input int ivc, input logic req);
      vca_pkg::vc_req_t r;
      r.req       = req;
      r.route_op  = vca_pkg::port_oh_t'(1 << ($unsigned($random(seed)) % vca_pkg::num_ports));
      r.route_orc = 2'(1 << ($unsigned($random(seed)) % 2));
      req_ip_ivc[ip][ivc] <= r;
   endtask

   task automatic random_elig;
      for (int p = 0; p < vca_pkg::num_ports; p++)
         elig_op_ovc[p] <= vca_pkg::vc_oh_u'($random(seed));
   endtask

   task automatic apply_reset;
      rst_n   <= 1'b0;
      test_id <= 0;
      clear_requests();
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // ----------------------------------------------------------------------
   // test phases
   // ----------------------------------------------------------------------

   task automatic run_single_req;
      test_id <= 1;
      repeat (single_cycles)
      begin
         clear_requests();
         random_request($unsigned($random(seed)) % 5, $unsigned($random(seed)) % 8, 1'b1);
         for (int p = 0; p < vca_pkg::num_ports; p++)
            elig_op_ovc[p] <= '1;
         @(posedge clk);
      end
   endtask

   // id 2 is full contention, id 3 also blocks one port
   task automatic run_random(input int id, input int cycles);
      test_id <= id;
      repeat (cycles)
      begin
         for (int ip = 0; ip < vca_pkg::num_ports; ip++)
            for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
               random_request(ip, ivc, 1'($random(seed)));
         random_elig();
         if (id == 3)
            elig_op_ovc[blocked_port] <= '0;
         @(posedge clk);
      end
   endtask

   task automatic run_last_class_route;
      vca_pkg::vc_req_t r;
      test_id <= 4;
      repeat (last_class_cycles)
      begin
         for (int ip = 0; ip < vca_pkg::num_ports; ip++)
            for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
            begin
               r.req       = ((ivc / 2) % 2 == 1) ? 1'($random(seed)) : 1'b0;
               r.route_op  = vca_pkg::port_oh_t'(1 << ($unsigned($random(seed)) % 5));
               r.route_orc = 2'b01;
               req_ip_ivc[ip][ivc] <= r;
            end
         random_elig();
         @(posedge clk);
      end
   endtask

   // every port asks for output VC 0 of port 0
   task automatic run_rr_fairness;
      test_id <= 5;
      for (int ip = 0; ip < vca_pkg::num_ports; ip++)
         req_ip_ivc[ip][0] <= '{req: 1'b1, route_op: 5'b00001, route_orc: 2'b01};
      elig_op_ovc[0] <= vca_pkg::vc_oh_u'(8'h01);
      repeat (rr_cycles) @(posedge clk);
   endtask

   initial
   begin
      clk     = 1'b0;
      rst_n   = 1'b0;
      test_id = 0;
      seed    = 32'hb385_cb11;
      for (int p = 0; p < vca_pkg::num_ports; p++)
      begin
         elig_op_ovc[p] = '0;
         for (int v = 0; v < vca_pkg::num_vcs; v++)
            req_ip_ivc[p][v] = '0;
      end
      apply_reset();
      run_single_req();
      run_random(2, contention_cycles);
      run_random(3, inelig_cycles);
      run_last_class_route();
      // fresh pointers so the port order starts at port 0
      apply_reset();
      run_rr_fairness();
      clear_requests();
      test_id <= 6;
      repeat (3) @(posedge clk);
      if (err_count == 0 && DUT.u_assertions.fail_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // watchdog
   initial
   begin
      #(2 * total_cycles * clk_period);
      $display("timeout: the tests did not finish in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/vca_assertions.sv
// VC allocator grant assertions
`timescale 1ns/1ps
`default_nettype none

module vca_assertions
(
   input logic              clk,
   input logic              rst_n,
   input vca_pkg::vc_req_t  req_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   input vca_pkg::vc_oh_u   elig_op_ovc [vca_pkg::num_ports],
   input vca_pkg::ivc_gnt_t gnt_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   input vca_pkg::ovc_gnt_t gnt_op_ovc  [vca_pkg::num_ports][vca_pkg::num_vcs]
);

   int fail_count = 0;

   for (genvar p = 0; p < vca_pkg::num_ports; p++)
   begin : g_p
      for (genvar v = 0; v < vca_pkg::num_vcs; v++)
      begin : g_v
         // at most one output VC per input VC
         a_one_ovc: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(gnt_ip_ivc[p][v].sel_ovc.flat))
            else begin fail_count++; $error("input VC holds several output VCs"); end
         // a named winner means the input side saw this VC as free
         a_elig: assert property (@(posedge clk) disable iff (!rst_n)
            (|gnt_op_ovc[p][v].sel_ip) |-> elig_op_ovc[p].flat[v])
            else begin fail_count++; $error("busy output VC granted"); end
         a_req: assert property (@(posedge clk) disable iff (!rst_n)
            gnt_ip_ivc[p][v].gnt |-> req_ip_ivc[p][v].req)
            else begin fail_count++; $error("grant without request"); end
      end
   end

endmodule

bind vc_alloc_sep_if vca_assertions u_assertions
(
   .clk         (clk),
   .rst_n       (rst_n),
   .req_ip_ivc  (req_ip_ivc),
   .elig_op_ovc (elig_op_ovc),
   .gnt_ip_ivc  (gnt_ip_ivc),
   .gnt_op_ovc  (gnt_op_ovc)
);

`default_nettype wire

// File: dv/vca_checker.sv
// VC allocator reference checker
`timescale 1ns/1ps
`default_nettype none

module vca_checker
(
   input  logic clk,
   input  logic rst_n,
   input  int   test_id,
   output int   err_count
);

   localparam int done_id      = 6;
   localparam int blocked_port = 2;

   // model pointers, same shape as the ones in the control module
   int in_ptr_m  [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_resource_classes];
   int ovc_ptr_m [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_ports];
   int oip_ptr_m [vca_pkg::num_ports][vca_pkg::num_vcs];
   // winners of the current cycle, -1 when nothing won
   int win_ip_m  [vca_pkg::num_ports][vca_pkg::num_vcs];
   int win_cvc_m [vca_pkg::num_ports][vca_pkg::num_vcs];

   vca_pkg::ovc_gnt_t exp_ovc [vca_pkg::num_ports][vca_pkg::num_vcs];
   vca_pkg::ivc_gnt_t exp_ivc [vca_pkg::num_ports][vca_pkg::num_vcs];

   int test_errs;
   int test_checks;
   int tests_passed;
   int tests_failed;
   int prev_id;
   int rr_cycle;

   initial
   begin
      err_count    = 0;
      test_errs    = 0;
      test_checks  = 0;
      tests_passed = 0;
      tests_failed = 0;
      prev_id      = 0;
      rr_cycle     = 0;
      in_ptr_m     = '{default: 0};
      ovc_ptr_m    = '{default: 0};
      oip_ptr_m    = '{default: 0};
   end

   function automatic string test_name(input int id);
      case (id)
         1:       return "single_req";
         2:       return "random_contention";
         3:       return "inelig_mask";
         4:       return "last_class_route";
         5:       return "rr_fairness";
         default: return "idle";
      endcase
   endfunction

   // first set bit at or above ptr, wrapping, -1 if none
   function automatic int rr_first(input logic [7:0] mask, input int width, input int ptr);
      int idx;
      for (int i = 0; i < width; i++)
      begin
         idx = (ptr + i) % width;
         if (mask[idx])
            return idx;
      end
      return -1;
   endfunction

   task automatic value_error(input string what, input int a, input int b,
                              input logic [13:0] exp_v, input logic [13:0] act_v);
      $display("FAIL %s %s[%0d][%0d] expected %h actual %h",
               test_name(test_id), what, a, b, exp_v, act_v);
      test_errs++;
      err_count++;
   endtask

   task automatic plain_error(input string msg);
      $display("%s: %s", test_name(test_id), msg);
      test_errs++;
      err_count++;
   endtask

   // ----------------------------------------------------------------------
   // expected grants from the allocation rules
   // ----------------------------------------------------------------------

   task automatic compute_expected;
      vca_pkg::vc_req_t r;
      logic [3:0]       req_cvc [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_ports];
      logic [7:0]       el;
      logic [1:0]       orc_mask;
      logic [4:0]       port_mask;
      int               op;
      int               mc;
      int               pick;
      int               w_ip;
      int               w_cvc;

      req_cvc = '{default: '0};
      for (int ip = 0; ip < vca_pkg::num_ports; ip++)
         for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
         begin
            exp_ivc[ip][ivc] = '0;
            r = tb_vc_alloc.DUT.req_ip_ivc[ip][ivc];
            op = -1;
            for (int p = 0; p < vca_pkg::num_ports; p++)
               if (r.route_op[p] && op < 0)
                  op = p;
            mc = ivc / 4;
            // last resource class may only move on in the last resource class
            orc_mask = (((ivc / 2) % 2) == 1) ? 2'b10 : r.route_orc;
            if (r.req && op >= 0)
            begin
               el = tb_vc_alloc.DUT.elig_op_ovc[op].flat;
               for (int orc = 0; orc < 2; orc++)
               begin
                  if (orc_mask[orc])
                  begin
                     pick = rr_first({6'b0, el[mc*4+orc*2 +: 2]}, 2, in_ptr_m[ip][ivc][orc]);
                     if (pick >= 0)
                        req_cvc[op][mc*4+orc*2+pick][ip][ivc%4] = 1'b1;
                  end
               end
            end
         end

      // output side, one port then one class VC of that port
      for (int o = 0; o < vca_pkg::num_ports; o++)
         for (int ovc = 0; ovc < vca_pkg::num_vcs; ovc++)
         begin
            exp_ovc[o][ovc]   = '0;
            win_ip_m[o][ovc]  = -1;
            win_cvc_m[o][ovc] = -1;
            mc                = ovc / 4;
            port_mask         = '0;
            for (int ip = 0; ip < vca_pkg::num_ports; ip++)
               port_mask[ip] = |req_cvc[o][ovc][ip];
            w_ip = rr_first({3'b0, port_mask}, 5, oip_ptr_m[o][ovc]);
            if (w_ip >= 0)
            begin
               w_cvc = rr_first({4'b0, req_cvc[o][ovc][w_ip]}, 4, ovc_ptr_m[o][ovc][w_ip]);
               exp_ovc[o][ovc].gnt                         = tb_vc_alloc.DUT.elig_op_ovc[o].flat[ovc];
               exp_ovc[o][ovc].sel_ip[w_ip]                = 1'b1;
               exp_ovc[o][ovc].sel_ivc.flat[mc*4+w_cvc]    = 1'b1;
               exp_ivc[w_ip][mc*4+w_cvc].sel_ovc.flat[ovc] = 1'b1;
               exp_ivc[w_ip][mc*4+w_cvc].gnt               = 1'b1;
               win_ip_m[o][ovc]  = w_ip;
               win_cvc_m[o][ovc] = w_cvc;
            end
         end
   endtask

   // ----------------------------------------------------------------------
   // compare at the falling edge, inputs are stable here
   // ----------------------------------------------------------------------

   always @(negedge clk)
   begin
      if (test_id != prev_id)
      begin
         if (prev_id != 0 && prev_id != done_id)
         begin
            $display("test %s: %0d checks, %0d errors", test_name(prev_id),
                     test_checks, test_errs);
            if (test_errs == 0)
               tests_passed++;
            else
               tests_failed++;
         end
         if (test_id == done_id)
            $display("tests passed %0d, failed %0d, errors %0d",
                     tests_passed, tests_failed, err_count);
         prev_id     = test_id;
         rr_cycle    = 0;
         test_errs   = 0;
         test_checks = 0;
      end

      compute_expected();

      if (rst_n && test_id != 0 && test_id != done_id)
      begin
         for (int o = 0; o < vca_pkg::num_ports; o++)
            for (int v = 0; v < vca_pkg::num_vcs; v++)
            begin
               test_checks += 2;
               if (tb_vc_alloc.DUT.gnt_op_ovc[o][v] !== exp_ovc[o][v])
                  value_error("gnt_op_ovc", o, v, exp_ovc[o][v],
                              tb_vc_alloc.DUT.gnt_op_ovc[o][v]);
               if (tb_vc_alloc.DUT.gnt_ip_ivc[o][v] !== exp_ivc[o][v])
                  value_error("gnt_ip_ivc", o, v, {5'b0, exp_ivc[o][v]},
                              {5'b0, tb_vc_alloc.DUT.gnt_ip_ivc[o][v]});
               // blocked port must stay silent in both directions
               if (test_id == 3 && o == blocked_port
                   && tb_vc_alloc.DUT.gnt_op_ovc[o][v].sel_ip != '0)
                  plain_error("an output VC of the blocked port named a winner");
               if (test_id == 3 && tb_vc_alloc.DUT.gnt_ip_ivc[o][v].gnt
                   && tb_vc_alloc.DUT.req_ip_ivc[o][v].route_op[blocked_port])
                  plain_error("an input VC routed to the blocked port was granted");
               // only VCs 2, 3, 6 and 7 are in the last resource class
               if (test_id == 4 && (tb_vc_alloc.DUT.gnt_ip_ivc[o][v].sel_ovc.flat & 8'h33) != 0)
                  plain_error("a grant left the last resource class");
            end
         if (test_id == 5 && rr_cycle < vca_pkg::num_ports)
         begin
            test_checks++;
            if (tb_vc_alloc.DUT.gnt_op_ovc[0][0].sel_ip != 5'(1 << rr_cycle))
               value_error("sel_ip", 0, 0, 14'(1 << rr_cycle),
                           {9'b0, tb_vc_alloc.DUT.gnt_op_ovc[0][0].sel_ip});
            rr_cycle++;
         end
      end
   end

   // ----------------------------------------------------------------------
   // model pointer update
   // ----------------------------------------------------------------------

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         in_ptr_m  = '{default: 0};
         ovc_ptr_m = '{default: 0};
         oip_ptr_m = '{default: 0};
      end
      else
      begin
         for (int o = 0; o < vca_pkg::num_ports; o++)
            for (int v = 0; v < vca_pkg::num_vcs; v++)
            begin
               if (exp_ovc[o][v].gnt)
               begin
                  oip_ptr_m[o][v] = (win_ip_m[o][v] + 1) % 5;
                  ovc_ptr_m[o][v][win_ip_m[o][v]] = (win_cvc_m[o][v] + 1) % 4;
               end
               // input pointer of class (k / 2) % 2 moves past class VC k % 2
               for (int k = 0; k < vca_pkg::num_vcs; k++)
                  if (exp_ivc[o][v].sel_ovc.flat[k])
                     in_ptr_m[o][v][(k / 2) % 2] = (k % 2 + 1) % 2;
            end
      end
   end

endmodule

`default_nettype wire

// File: src/vc_alloc_sep_if.sv
// Separable input-first VC allocator
`timescale 1ns/1ps
`default_nettype none

module vc_alloc_sep_if
(
   input  logic              clk,
   input  logic              rst_n,
   input  vca_pkg::vc_req_t  req_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   // set bit means that output VC is free
   input  vca_pkg::vc_oh_u   elig_op_ovc [vca_pkg::num_ports],
   output vca_pkg::ivc_gnt_t gnt_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   output vca_pkg::ovc_gnt_t gnt_op_ovc  [vca_pkg::num_ports][vca_pkg::num_vcs]
);

   vca_pkg::vc_oh_u      in_req     [vca_pkg::num_ports][vca_pkg::num_vcs];
   vca_pkg::in_ptr_t     in_ptr
             [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_resource_classes];
   vca_pkg::out_vc_ptr_t out_vc_ptr [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_ports];
   vca_pkg::out_ip_ptr_t out_ip_ptr [vca_pkg::num_ports][vca_pkg::num_vcs];

   vca_input_stage u_input_stage
   (
      .req_ip_ivc  (req_ip_ivc),
      .elig_op_ovc (elig_op_ovc),
      .in_ptr      (in_ptr),
      .in_req      (in_req)
   );

   vca_output_stage u_output_stage
   (
      .in_req      (in_req),
      .req_ip_ivc  (req_ip_ivc),
      .elig_op_ovc (elig_op_ovc),
      .out_vc_ptr  (out_vc_ptr),
      .out_ip_ptr  (out_ip_ptr),
      .gnt_op_ovc  (gnt_op_ovc)
   );

   vca_priority_ctrl u_priority_ctrl
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .gnt_ip_ivc (gnt_ip_ivc),
      .gnt_op_ovc (gnt_op_ovc),
      .in_ptr     (in_ptr),
      .out_vc_ptr (out_vc_ptr),
      .out_ip_ptr (out_ip_ptr)
   );

   // ----------------------------------------------------------------------
   // transpose output-side winners into per input VC grants
   // ----------------------------------------------------------------------

   // routing is one-hot, so OR over all output ports is safe
   always_comb
   begin
      for (int ip = 0; ip < vca_pkg::num_ports; ip++)
         for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
         begin
            gnt_ip_ivc[ip][ivc] = '0;
            for (int op = 0; op < vca_pkg::num_ports; op++)
               for (int ovc = 0; ovc < vca_pkg::num_vcs; ovc++)
               begin
                  if (gnt_op_ovc[op][ovc].sel_ip[ip] && gnt_op_ovc[op][ovc].sel_ivc.flat[ivc])
                     gnt_ip_ivc[ip][ivc].sel_ovc.flat[ovc] = 1'b1;
               end
            gnt_ip_ivc[ip][ivc].gnt = |gnt_ip_ivc[ip][ivc].sel_ovc.flat;
         end
   end

endmodule

`default_nettype wire

// File: src/vca_input_stage.sv
// VC allocator input-side arbitration
`timescale 1ns/1ps
`default_nettype none

module vca_input_stage
(
   input  vca_pkg::vc_req_t req_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   input  vca_pkg::vc_oh_u  elig_op_ovc [vca_pkg::num_ports],
   input  vca_pkg::in_ptr_t in_ptr
             [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_resource_classes],
   // one-hot output VC request per input VC, aimed at its route_op port
   output vca_pkg::vc_oh_u  in_req      [vca_pkg::num_ports][vca_pkg::num_vcs]
);

   for (genvar ip = 0; ip < vca_pkg::num_ports; ip++)
   begin : g_ip
      for (genvar ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
      begin : g_ivc

         // ----------------------------------------------------------------
         // eligibility of the routed port
         // ----------------------------------------------------------------

         vca_pkg::vc_oh_u                          elig_word;
         vca_pkg::class_oh_t                       pick;
         logic [vca_pkg::num_resource_classes-1:0] orc_mask;
         vca_pkg::vc_oh_u                          req_word;

         // route_op is one-hot, so an OR of the masked words is the select
         always_comb
         begin
            elig_word = '0;
            for (int p = 0; p < vca_pkg::num_ports; p++)
            begin
               if (req_ip_ivc[ip][ivc].route_op[p])
                  elig_word.flat = elig_word.flat | elig_op_ovc[p].flat;
            end
         end

         // ----------------------------------------------------------------
         // one arbiter per output resource class
         // ----------------------------------------------------------------

         // arbitration runs regardless of req, masking comes afterwards
         for (genvar orc = 0; orc < vca_pkg::num_resource_classes; orc++)
         begin : g_orc
            vca_rr_pick
            #(
               .width (vca_pkg::num_vcs_per_class)
            )
            u_pick
            (
               .req (elig_word.cls[vca_pkg::vc_mc(ivc)][orc]),
               .ptr (in_ptr[ip][ivc][orc]),
               .gnt (pick[orc])
            );
         end

         // ----------------------------------------------------------------
         // route masking
         // ----------------------------------------------------------------

         always_comb
         begin
            orc_mask = req_ip_ivc[ip][ivc].route_orc;
            // last resource class stays in the last resource class
            if (vca_pkg::vc_rc(ivc) == vca_pkg::num_resource_classes - 1)
            begin
               orc_mask = '0;
               orc_mask[vca_pkg::num_resource_classes-1] = 1'b1;
            end
            req_word = '0;
            for (int orc = 0; orc < vca_pkg::num_resource_classes; orc++)
            begin
               if (req_ip_ivc[ip][ivc].req && orc_mask[orc])
                  req_word.cls[vca_pkg::vc_mc(ivc)][orc] = pick[orc];
            end
         end

         assign in_req[ip][ivc] = req_word;

      end
   end

endmodule

`default_nettype wire

// File: src/vca_output_stage.sv
// VC allocator output-side arbitration
`timescale 1ns/1ps
`default_nettype none

module vca_output_stage
(
   input  vca_pkg::vc_oh_u     in_req      [vca_pkg::num_ports][vca_pkg::num_vcs],
   // only route_op is read here, req and route_orc are already in in_req
   input  vca_pkg::vc_req_t    req_ip_ivc  [vca_pkg::num_ports][vca_pkg::num_vcs],
   input  vca_pkg::vc_oh_u     elig_op_ovc [vca_pkg::num_ports],
   input  vca_pkg::out_vc_ptr_t out_vc_ptr
             [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_ports],
   input  vca_pkg::out_ip_ptr_t out_ip_ptr [vca_pkg::num_ports][vca_pkg::num_vcs],
   output vca_pkg::ovc_gnt_t   gnt_op_ovc  [vca_pkg::num_ports][vca_pkg::num_vcs]
);

   for (genvar op = 0; op < vca_pkg::num_ports; op++)
   begin : g_op
      for (genvar mc = 0; mc < vca_pkg::num_message_classes; mc++)
      begin : g_mc
         for (genvar orc = 0; orc < vca_pkg::num_resource_classes; orc++)
         begin : g_orc
            for (genvar ocvc = 0; ocvc < vca_pkg::num_vcs_per_class; ocvc++)
            begin : g_ocvc

               // requesters per input port, one bit per class VC of class mc
               logic [vca_pkg::num_ports-1:0][vca_pkg::num_class_vcs-1:0] req_cvc;
               logic [vca_pkg::num_ports-1:0][vca_pkg::num_class_vcs-1:0] win_cvc;
               logic [vca_pkg::num_ports-1:0]                            req_port;
               vca_pkg::port_oh_t                                        win_port;
               logic [vca_pkg::num_class_vcs-1:0]                        sel_cvc;
               vca_pkg::vc_oh_u                                          sel_word;

               // only input VCs of the same message class can ask for this VC
               always_comb
               begin
                  for (int ip = 0; ip < vca_pkg::num_ports; ip++)
                  begin
                     for (int icv = 0; icv < vca_pkg::num_class_vcs; icv++)
                     begin
                        req_cvc[ip][icv] =
                           in_req[ip][mc * vca_pkg::num_class_vcs + icv].cls[mc][orc][ocvc]
                           & req_ip_ivc[ip][mc * vca_pkg::num_class_vcs + icv].route_op[op];
                     end
                  end
               end

               // -------------------------------------------------------------
               // pick one input VC per input port
               // -------------------------------------------------------------

               for (genvar ip = 0; ip < vca_pkg::num_ports; ip++)
               begin : g_ip
                  assign req_port[ip] = |req_cvc[ip];

                  vca_rr_pick
                  #(
                     .width (vca_pkg::num_class_vcs)
                  )
                  u_vc_pick
                  (
                     .req (req_cvc[ip]),
                     .ptr (out_vc_ptr[op][vca_pkg::vc_index(mc, orc, ocvc)][ip]),
                     .gnt (win_cvc[ip])
                  );
               end

               // -------------------------------------------------------------
               // pick one input port among the requesting ones
               // -------------------------------------------------------------

               vca_rr_pick
               #(
                  .width (vca_pkg::num_ports)
               )
               u_ip_pick
               (
                  .req (req_port),
                  .ptr (out_ip_ptr[op][vca_pkg::vc_index(mc, orc, ocvc)]),
                  .gnt (win_port)
               );

               // winning port's class VC, placed back into its message class
               always_comb
               begin
                  sel_cvc = '0;
                  for (int ip = 0; ip < vca_pkg::num_ports; ip++)
                  begin
                     if (win_port[ip])
                        sel_cvc = sel_cvc | win_cvc[ip];
                  end
                  sel_word         = '0;
                  sel_word.cls[mc] = sel_cvc;
               end

               // eligibility only qualifies the grant flag
               assign gnt_op_ovc[op][vca_pkg::vc_index(mc, orc, ocvc)] = '{
                  gnt:     (|req_port) & elig_op_ovc[op].cls[mc][orc][ocvc],
                  sel_ip:  win_port,
                  sel_ivc: sel_word
               };

            end
         end
      end
   end

endmodule

`default_nettype wire

// File: src/vca_pkg.sv
// VC allocator shared definitions
`default_nettype none

package vca_pkg;

   // ----------------------------------------------------------------------
   // router and VC sizing
   // ----------------------------------------------------------------------

   localparam int num_ports            = 5;
   localparam int num_message_classes  = 2;
   localparam int num_resource_classes = 2;
   localparam int num_vcs_per_class    = 2;
   // VCs per port, message class is the outermost field
   localparam int num_vcs       = num_message_classes * num_resource_classes * num_vcs_per_class;
   // VCs of one message class on a port
   localparam int num_class_vcs = num_resource_classes * num_vcs_per_class;

   localparam int port_idx_w     = 3;
   localparam int vc_idx_w       = 3;
   localparam int class_vc_idx_w = 2;
   localparam int cvc_idx_w      = 1;

   // ----------------------------------------------------------------------
   // index helpers
   // ----------------------------------------------------------------------

   // VC index = (message class * 2 + resource class) * 2 + class VC
   function automatic logic [vc_idx_w-1:0] vc_index(input int mc, input int rc, input int cvc);
      return vc_idx_w'((mc * num_resource_classes + rc) * num_vcs_per_class + cvc);
   endfunction

   // message class of a VC index
   function automatic int vc_mc(input int vc);
      return vc / num_class_vcs;
   endfunction

   // resource class of a VC index
   function automatic int vc_rc(input int vc);
      return (vc / num_vcs_per_class) % num_resource_classes;
   endfunction

   // ----------------------------------------------------------------------
   // types
   // ----------------------------------------------------------------------

   typedef logic [num_ports-1:0] port_oh_t;

   // one message class worth of VC bits, indexed [resource class][class VC]
   typedef logic [num_resource_classes-1:0][num_vcs_per_class-1:0] class_oh_t;

   // flat view for selects, decoded view for slicing out a message class
   typedef union packed
   {
      logic [num_vcs-1:0]                  flat;
      class_oh_t [num_message_classes-1:0] cls;
   } vc_oh_u;

   // request of one input VC
   typedef struct packed
   {
      logic                            req;
      port_oh_t                        route_op;
      logic [num_resource_classes-1:0] route_orc;
   } vc_req_t;

   // grant toward the input controller
   typedef struct packed
   {
      logic   gnt;
      vc_oh_u sel_ovc;
   } ivc_gnt_t;

   // grant toward the output controller
   typedef struct packed
   {
      logic     gnt;
      port_oh_t sel_ip;
      vc_oh_u   sel_ivc;
   } ovc_gnt_t;

   // round-robin pointers
   typedef logic [cvc_idx_w-1:0]      in_ptr_t;
   typedef logic [class_vc_idx_w-1:0] out_vc_ptr_t;
   typedef logic [port_idx_w-1:0]     out_ip_ptr_t;

endpackage

`default_nettype wire

// File: src/vca_priority_ctrl.sv
// VC allocator round-robin pointer control
`timescale 1ns/1ps
`default_nettype none

module vca_priority_ctrl
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  vca_pkg::ivc_gnt_t     gnt_ip_ivc [vca_pkg::num_ports][vca_pkg::num_vcs],
   input  vca_pkg::ovc_gnt_t     gnt_op_ovc [vca_pkg::num_ports][vca_pkg::num_vcs],
   output vca_pkg::in_ptr_t      in_ptr
             [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_resource_classes],
   output vca_pkg::out_vc_ptr_t  out_vc_ptr
             [vca_pkg::num_ports][vca_pkg::num_vcs][vca_pkg::num_ports],
   output vca_pkg::out_ip_ptr_t  out_ip_ptr [vca_pkg::num_ports][vca_pkg::num_vcs]
);

   // ----------------------------------------------------------------------
   // input side, one pointer per input VC and output resource class
   // ----------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         in_ptr <= '{default: '0};
      else
      begin
         for (int ip = 0; ip < vca_pkg::num_ports; ip++)
            for (int ivc = 0; ivc < vca_pkg::num_vcs; ivc++)
               for (int orc = 0; orc < vca_pkg::num_resource_classes; orc++)
                  for (int c = 0; c < vca_pkg::num_vcs_per_class; c++)
                  begin
                     // granted class VC in resource class orc, move one past it
                     if (gnt_ip_ivc[ip][ivc].sel_ovc.cls[vca_pkg::vc_mc(ivc)][orc][c])
                        in_ptr[ip][ivc][orc] <=
                           vca_pkg::in_ptr_t'((c + 1) % vca_pkg::num_vcs_per_class);
                  end
      end
   end

   // ----------------------------------------------------------------------
   // output side, input VC pointers per port and the port pointer
   // ----------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_vc_ptr <= '{default: '0};
         out_ip_ptr <= '{default: '0};
      end
      else
      begin
         for (int op = 0; op < vca_pkg::num_ports; op++)
            for (int ovc = 0; ovc < vca_pkg::num_vcs; ovc++)
               for (int ip = 0; ip < vca_pkg::num_ports; ip++)
               begin
                  if (gnt_op_ovc[op][ovc].gnt && gnt_op_ovc[op][ovc].sel_ip[ip])
                  begin
                     // port pointer moves past the winning port
                     out_ip_ptr[op][ovc] <=
                        vca_pkg::out_ip_ptr_t'((ip + 1) % vca_pkg::num_ports);
                     // winner's class VC index = resource class * 2 + class VC
                     for (int c = 0; c < vca_pkg::num_class_vcs; c++)
                     begin
                        if (gnt_op_ovc[op][ovc].sel_ivc.cls[vca_pkg::vc_mc(ovc)]
                               [c / vca_pkg::num_vcs_per_class][c % vca_pkg::num_vcs_per_class])
                           out_vc_ptr[op][ovc][ip] <=
                              vca_pkg::out_vc_ptr_t'((c + 1) % vca_pkg::num_class_vcs);
                     end
                  end
               end
      end
   end

endmodule

`default_nettype wire

// File: src/vca_rr_pick.sv
// Round-robin one-hot picker
`timescale 1ns/1ps
`default_nettype none

module vca_rr_pick
#(
   parameter int width = 4
)
(
   input  logic [width-1:0]         req,
   // highest priority position, kept by the control module
   input  logic [$clog2(width)-1:0] ptr,
   output logic [width-1:0]         gnt
);

   // scan upward from ptr and wrap, first set request wins
   always_comb
   begin
      logic found;
      int   idx;

      gnt   = '0;
      found = 1'b0;
      for (int i = 0; i < width; i++)
      begin
         // position i steps above the pointer
         idx = (int'(ptr) + i) % width;
         if (!found && req[idx])
         begin
            gnt[idx] = 1'b1;
            found    = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
src/vca_pkg.sv
src/vca_rr_pick.sv
src/vca_input_stage.sv
src/vca_output_stage.sv
src/vca_priority_ctrl.sv
src/vc_alloc_sep_if.sv
dv/vca_assertions.sv
dv/vca_checker.sv
dv/tb_vc_alloc.sv
